// File: design/sched_cfg_pkg.sv
`default_nettype none

package sched_cfg_pkg;

  // Scheduler defaults, overridden through the top level parameters
  localparam int DEFAULT_CORE_COUNT      = 16;
  localparam int DEFAULT_SLOT_COUNT      = 8;
  localparam int DEFAULT_INTERFACE_COUNT = 2;
  localparam int DEFAULT_DATA_WIDTH      = 64;

  // Slot tag inside a destination is never narrower than this
  localparam int MIN_TAG_WIDTH = 5;

endpackage

`default_nettype wire

// File: design/sched_msg_pkg.sv
`default_nettype none

package sched_msg_pkg;

  // Control word is the message kind on top of a 32-bit descriptor
  localparam int CTRL_WIDTH     = 36;
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int DESC_WIDTH     = CTRL_WIDTH - MSG_TYPE_WIDTH;

  // Slot number position inside an incoming descriptor
  localparam int SLOT_FIELD_LSB = 16;

  // Kind 0 doubles as send out on the outgoing stream
  typedef enum logic [MSG_TYPE_WIDTH-1:0] {
    MSG_SLOT_RETURN = 4'd0,
    MSG_PKT_DONE    = 4'd1,
    MSG_TO_CORE     = 4'd2,
    MSG_SLOT_INIT   = 4'd3
  } msg_kind_e;

endpackage

`default_nettype wire

// File: design/ctrl_msg_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module ctrl_msg_decoder #(
  parameter int  CORE_COUNT    = sched_cfg_pkg::DEFAULT_CORE_COUNT,
  parameter int  SLOT_COUNT    = sched_cfg_pkg::DEFAULT_SLOT_COUNT,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT)
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [sched_msg_pkg::CTRL_WIDTH-1:0] ctrl_s_data,
  input  logic [CORE_ID_WIDTH-1:0]            ctrl_s_src,
  input  logic                                ctrl_s_valid,
  output logic                                ctrl_s_ready,
  input  logic                                done_full,
  output logic [CORE_COUNT-1:0]               slot_return_strobe,
  output logic [CORE_COUNT-1:0]               slot_init_strobe,
  output logic [SLOT_WIDTH-1:0]               slot_value,
  output logic                                done_push,
  output logic [CORE_ID_WIDTH-1:0]            done_src,
  output logic [sched_msg_pkg::DESC_WIDTH-1:0] done_desc
);

  import sched_msg_pkg::*;

  msg_kind_e kind;
  logic      accept;

  assign kind   = msg_kind_e'(ctrl_s_data[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH]);
  assign accept = ctrl_s_valid && ctrl_s_ready;

  // Only packet done can stall, everything else is always taken
  always_comb begin
    case (kind)
      MSG_PKT_DONE: ctrl_s_ready = !done_full;
      default:      ctrl_s_ready = 1'b1;
    endcase
  end

  assign done_push = accept && (kind == MSG_PKT_DONE);
  assign done_src  = ctrl_s_src;
  assign done_desc = ctrl_s_data[DESC_WIDTH-1:0];

  // One-hot strobes by source core, slot field rides alongside
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_return_strobe <= '0;
      slot_init_strobe   <= '0;
    end else begin
      slot_return_strobe <= '0;
      slot_init_strobe   <= '0;
      if (accept && (kind == MSG_SLOT_RETURN)) begin
        slot_return_strobe[ctrl_s_src] <= 1'b1;
      end
      if (accept && (kind == MSG_SLOT_INIT)) begin
        slot_init_strobe[ctrl_s_src] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    slot_value <= ctrl_s_data[SLOT_FIELD_LSB +: SLOT_WIDTH];
  end

endmodule

`default_nettype wire

// File: design/slot_keeper.sv
`timescale 1ns/100ps
`default_nettype none

module slot_keeper #(
  parameter int  SLOT_COUNT = sched_cfg_pkg::DEFAULT_SLOT_COUNT,
  localparam int SLOT_WIDTH = $clog2(SLOT_COUNT + 1),
  localparam int PTR_WIDTH  = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  init_strobe,
  input  logic                  return_strobe,
  input  logic [SLOT_WIDTH-1:0] slot_value,
  input  logic                  pop,
  output logic [SLOT_WIDTH-1:0] head_slot,
  output logic                  head_valid,
  output logic [SLOT_WIDTH-1:0] slot_count
);

  logic [SLOT_WIDTH-1:0] slots [SLOT_COUNT];
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [SLOT_WIDTH-1:0] init_len;
  logic                  do_push;
  logic                  do_pop;

  function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(SLOT_COUNT - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Init lengths beyond the queue size are clamped
  assign init_len = (slot_value > SLOT_WIDTH'(SLOT_COUNT)) ? SLOT_WIDTH'(SLOT_COUNT)
                                                           : slot_value;

  assign head_valid = (slot_count != '0);
  assign head_slot  = slots[rd_ptr];
  assign do_pop     = pop && head_valid;
  assign do_push    = return_strobe && (slot_count != SLOT_WIDTH'(SLOT_COUNT));

  always_ff @(posedge clk) begin
    if (init_strobe) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        slots[i] <= SLOT_WIDTH'(i + 1);
      end
    end else if (do_push) begin
      slots[wr_ptr] <= slot_value;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      slot_count <= '0;
    end else if (init_strobe) begin
      // Queue restarts holding slots 1 to init_len
      rd_ptr     <= '0;
      wr_ptr     <= (init_len == SLOT_WIDTH'(SLOT_COUNT)) ? '0 : PTR_WIDTH'(init_len);
      slot_count <= init_len;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   slot_count <= slot_count + 1'b1;
        2'b01:   slot_count <= slot_count - 1'b1;
        default: slot_count <= slot_count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/done_msg_queue.sv
`timescale 1ns/100ps
`default_nettype none

module done_msg_queue #(
  parameter int  CORE_COUNT    = sched_cfg_pkg::DEFAULT_CORE_COUNT,
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int DEPTH         = 8,
  localparam int PTR_WIDTH     = $clog2(DEPTH)
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                push,
  input  logic [CORE_ID_WIDTH-1:0]            push_src,
  input  logic [sched_msg_pkg::DESC_WIDTH-1:0] push_desc,
  output logic                                full,
  output logic [sched_msg_pkg::CTRL_WIDTH-1:0] ctrl_m_data,
  output logic [CORE_ID_WIDTH-1:0]            ctrl_m_dest,
  output logic                                ctrl_m_valid,
  input  logic                                ctrl_m_ready
);

  import sched_msg_pkg::*;

  localparam msg_kind_e SEND_OUT = MSG_SLOT_RETURN;

  logic [CORE_ID_WIDTH-1:0] src_mem  [DEPTH];
  logic [DESC_WIDTH-1:0]    desc_mem [DEPTH];
  logic [PTR_WIDTH-1:0]     rd_ptr;
  logic [PTR_WIDTH-1:0]     wr_ptr;
  logic [PTR_WIDTH:0]       fill;
  logic                     do_push;
  logic                     do_pop;

  assign full         = (fill == (PTR_WIDTH + 1)'(DEPTH));
  assign ctrl_m_valid = (fill != '0);
  assign do_push      = push && !full;
  assign do_pop       = ctrl_m_valid && ctrl_m_ready;

  // Head stays put until the core side takes it
  assign ctrl_m_data = {SEND_OUT, desc_mem[rd_ptr]};
  assign ctrl_m_dest = src_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      src_mem[wr_ptr]  <= push_src;
      desc_mem[wr_ptr] <= push_desc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      fill   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill <= fill + do_push - do_pop;
    end
  end

endmodule

`default_nettype wire

// File: design/max_slot_selector.sv
`timescale 1ns/100ps
`default_nettype none

module max_slot_selector #(
  parameter int  CORE_COUNT    = sched_cfg_pkg::DEFAULT_CORE_COUNT,
  parameter int  SLOT_COUNT    = sched_cfg_pkg::DEFAULT_SLOT_COUNT,
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int LEAF_COUNT    = 1 << CORE_ID_WIDTH,
  localparam int NODE_COUNT    = 2 * LEAF_COUNT - 1
) (
  input  logic [CORE_COUNT*SLOT_WIDTH-1:0] slot_counts,
  input  logic [CORE_COUNT-1:0]            income_cores,
  output logic [CORE_ID_WIDTH-1:0]         best_core,
  output logic                             best_valid
);

  // Heap-ordered tree, leaves at LEAF_COUNT-1 and up
  logic [SLOT_WIDTH-1:0]    node_count [NODE_COUNT];
  logic [CORE_ID_WIDTH-1:0] node_core  [NODE_COUNT];
  logic                     node_valid [NODE_COUNT];

  always_comb begin
    for (int i = 0; i < LEAF_COUNT; i++) begin
      node_count[LEAF_COUNT-1+i] = '0;
      node_core[LEAF_COUNT-1+i]  = CORE_ID_WIDTH'(i);
      node_valid[LEAF_COUNT-1+i] = 1'b0;
    end
    for (int i = 0; i < CORE_COUNT; i++) begin
      node_count[LEAF_COUNT-1+i] = slot_counts[i*SLOT_WIDTH +: SLOT_WIDTH];
      node_valid[LEAF_COUNT-1+i] = income_cores[i] &&
                                   (slot_counts[i*SLOT_WIDTH +: SLOT_WIDTH] != '0);
    end
    // Left child holds the lower indices, so it keeps ties
    for (int n = LEAF_COUNT - 2; n >= 0; n--) begin
      if (node_valid[2*n+2] &&
          (!node_valid[2*n+1] || (node_count[2*n+2] > node_count[2*n+1]))) begin
        node_count[n] = node_count[2*n+2];
        node_core[n]  = node_core[2*n+2];
        node_valid[n] = 1'b1;
      end else begin
        node_count[n] = node_count[2*n+1];
        node_core[n]  = node_core[2*n+1];
        node_valid[n] = node_valid[2*n+1];
      end
    end
  end

  assign best_core  = node_core[0];
  assign best_valid = node_valid[0];

endmodule

`default_nettype wire

// File: design/rx_dest_assigner.sv
`timescale 1ns/100ps
`default_nettype none

module rx_dest_assigner #(
  parameter int  CORE_COUNT      = sched_cfg_pkg::DEFAULT_CORE_COUNT,
  parameter int  SLOT_COUNT      = sched_cfg_pkg::DEFAULT_SLOT_COUNT,
  parameter int  INTERFACE_COUNT = sched_cfg_pkg::DEFAULT_INTERFACE_COUNT,
  localparam int SLOT_WIDTH      = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH   = $clog2(CORE_COUNT),
  localparam int TAG_WIDTH       = (SLOT_WIDTH > sched_cfg_pkg::MIN_TAG_WIDTH) ?
                                   SLOT_WIDTH : sched_cfg_pkg::MIN_TAG_WIDTH,
  localparam int DEST_WIDTH      = CORE_ID_WIDTH + TAG_WIDTH,
  localparam int IF_WIDTH        = (INTERFACE_COUNT > 1) ? $clog2(INTERFACE_COUNT) : 1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [INTERFACE_COUNT-1:0]            rx_valid,
  input  logic [INTERFACE_COUNT-1:0]            rx_last,
  output logic [INTERFACE_COUNT-1:0]            rx_ready,
  input  logic [INTERFACE_COUNT-1:0]            data_m_ready,
  output logic [INTERFACE_COUNT-1:0]            data_m_valid,
  output logic [INTERFACE_COUNT*DEST_WIDTH-1:0] data_m_dest,
  input  logic [CORE_ID_WIDTH-1:0]              best_core,
  input  logic                                  best_valid,
  input  logic [CORE_COUNT*SLOT_WIDTH-1:0]      head_slots,
  output logic [CORE_COUNT-1:0]                 slot_pop
);

  logic [INTERFACE_COUNT-1:0] dest_held;
  logic [INTERFACE_COUNT-1:0] last_accept;
  logic [INTERFACE_COUNT-1:0] request;
  logic [IF_WIDTH-1:0]        last_grant;
  logic [IF_WIDTH-1:0]        grant_idx;
  logic                       grant_valid;
  logic [DEST_WIDTH-1:0]      new_dest;

  assign rx_ready     = dest_held & data_m_ready;
  assign data_m_valid = dest_held & rx_valid;
  assign last_accept  = rx_valid & rx_last & rx_ready;

  // Ask again while the last word leaves so back-to-back packets keep going
  assign request  = (~dest_held | last_accept) & {INTERFACE_COUNT{best_valid}};
  assign new_dest = {best_core, TAG_WIDTH'(head_slots[best_core*SLOT_WIDTH +: SLOT_WIDTH])};

  // Round robin, the interface after the last grant goes first
  always_comb begin
    int unsigned cand;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int k = INTERFACE_COUNT; k >= 1; k--) begin
      cand = last_grant + k;
      if (cand >= INTERFACE_COUNT) begin
        cand = cand - INTERFACE_COUNT;
      end
      if (request[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = IF_WIDTH'(cand);
      end
    end
  end

  always_comb begin
    slot_pop = '0;
    if (grant_valid) begin
      slot_pop[best_core] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dest_held  <= '0;
      last_grant <= '0;
    end else begin
      dest_held <= dest_held & ~last_accept;
      if (grant_valid) begin
        dest_held[grant_idx] <= 1'b1;
        last_grant           <= grant_idx;
      end
    end
  end

  // Destination held for the whole packet
  always_ff @(posedge clk) begin
    if (grant_valid) begin
      data_m_dest[grant_idx*DEST_WIDTH +: DEST_WIDTH] <= new_dest;
    end
  end

endmodule

`default_nettype wire

// File: design/scheduler_top.sv
`timescale 1ns/100ps
`default_nettype none

module scheduler_top #(
  parameter int  CORE_COUNT      = sched_cfg_pkg::DEFAULT_CORE_COUNT,
  parameter int  SLOT_COUNT      = sched_cfg_pkg::DEFAULT_SLOT_COUNT,
  parameter int  INTERFACE_COUNT = sched_cfg_pkg::DEFAULT_INTERFACE_COUNT,
  parameter int  DATA_WIDTH      = sched_cfg_pkg::DEFAULT_DATA_WIDTH,
  localparam int KEEP_WIDTH      = DATA_WIDTH / 8,
  localparam int SLOT_WIDTH      = $clog2(SLOT_COUNT + 1),
  localparam int CORE_ID_WIDTH   = $clog2(CORE_COUNT),
  localparam int TAG_WIDTH       = (SLOT_WIDTH > sched_cfg_pkg::MIN_TAG_WIDTH) ?
                                   SLOT_WIDTH : sched_cfg_pkg::MIN_TAG_WIDTH,
  localparam int DEST_WIDTH      = CORE_ID_WIDTH + TAG_WIDTH
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [sched_msg_pkg::CTRL_WIDTH-1:0]  ctrl_s_data,
  input  logic [CORE_ID_WIDTH-1:0]              ctrl_s_src,
  input  logic                                  ctrl_s_valid,
  output logic                                  ctrl_s_ready,
  output logic [sched_msg_pkg::CTRL_WIDTH-1:0]  ctrl_m_data,
  output logic [CORE_ID_WIDTH-1:0]              ctrl_m_dest,
  output logic                                  ctrl_m_valid,
  input  logic                                  ctrl_m_ready,
  input  logic [INTERFACE_COUNT*DATA_WIDTH-1:0] rx_data,
  input  logic [INTERFACE_COUNT*KEEP_WIDTH-1:0] rx_keep,
  input  logic [INTERFACE_COUNT-1:0]            rx_valid,
  input  logic [INTERFACE_COUNT-1:0]            rx_last,
  output logic [INTERFACE_COUNT-1:0]            rx_ready,
  output logic [INTERFACE_COUNT*DATA_WIDTH-1:0] data_m_data,
  output logic [INTERFACE_COUNT*KEEP_WIDTH-1:0] data_m_keep,
  output logic [INTERFACE_COUNT-1:0]            data_m_valid,
  output logic [INTERFACE_COUNT-1:0]            data_m_last,
  output logic [INTERFACE_COUNT*DEST_WIDTH-1:0] data_m_dest,
  input  logic [INTERFACE_COUNT-1:0]            data_m_ready,
  input  logic [CORE_COUNT-1:0]                 income_cores,
  input  logic [CORE_ID_WIDTH-1:0]              slot_query_core,
  output logic [SLOT_WIDTH-1:0]                 slot_query_count
);

  import sched_msg_pkg::*;

  logic [CORE_COUNT-1:0]            slot_return_strobe;
  logic [CORE_COUNT-1:0]            slot_init_strobe;
  logic [SLOT_WIDTH-1:0]            slot_value;
  logic                             done_push;
  logic [CORE_ID_WIDTH-1:0]         done_src;
  logic [DESC_WIDTH-1:0]            done_desc;
  logic                             done_full;
  logic [CORE_COUNT*SLOT_WIDTH-1:0] head_slots;
  logic [CORE_COUNT*SLOT_WIDTH-1:0] slot_counts;
  logic [CORE_COUNT-1:0]            slot_pop;
  logic [CORE_ID_WIDTH-1:0]         best_core;
  logic                             best_valid;

  ctrl_msg_decoder #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) u_decoder (
    .clk(clk), .rst(rst),
    .ctrl_s_data(ctrl_s_data), .ctrl_s_src(ctrl_s_src),
    .ctrl_s_valid(ctrl_s_valid), .ctrl_s_ready(ctrl_s_ready),
    .done_full(done_full),
    .slot_return_strobe(slot_return_strobe), .slot_init_strobe(slot_init_strobe),
    .slot_value(slot_value),
    .done_push(done_push), .done_src(done_src), .done_desc(done_desc)
  );

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_keeper
    slot_keeper #(.SLOT_COUNT(SLOT_COUNT)) u_keeper (
      .clk(clk), .rst(rst),
      .init_strobe(slot_init_strobe[c]), .return_strobe(slot_return_strobe[c]),
      .slot_value(slot_value), .pop(slot_pop[c]),
      .head_slot(head_slots[c*SLOT_WIDTH +: SLOT_WIDTH]), .head_valid(),
      .slot_count(slot_counts[c*SLOT_WIDTH +: SLOT_WIDTH])
    );
  end

  max_slot_selector #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) u_selector (
    .slot_counts(slot_counts), .income_cores(income_cores),
    .best_core(best_core), .best_valid(best_valid)
  );

  rx_dest_assigner #(
    .CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT), .INTERFACE_COUNT(INTERFACE_COUNT)
  ) u_assigner (
    .clk(clk), .rst(rst),
    .rx_valid(rx_valid), .rx_last(rx_last), .rx_ready(rx_ready),
    .data_m_ready(data_m_ready), .data_m_valid(data_m_valid), .data_m_dest(data_m_dest),
    .best_core(best_core), .best_valid(best_valid),
    .head_slots(head_slots), .slot_pop(slot_pop)
  );

  done_msg_queue #(.CORE_COUNT(CORE_COUNT)) u_done_queue (
    .clk(clk), .rst(rst),
    .push(done_push), .push_src(done_src), .push_desc(done_desc), .full(done_full),
    .ctrl_m_data(ctrl_m_data), .ctrl_m_dest(ctrl_m_dest),
    .ctrl_m_valid(ctrl_m_valid), .ctrl_m_ready(ctrl_m_ready)
  );

  // Packet words go straight through, valid and ready are gated in the assigner
  assign data_m_data = rx_data;
  assign data_m_keep = rx_keep;
  assign data_m_last = rx_last;

  assign slot_query_count = slot_counts[slot_query_core*SLOT_WIDTH +: SLOT_WIDTH];

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // Released on a falling edge, clear of the sampling edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/tb_scheduler_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_scheduler_top;

  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  localparam int CORES = DEFAULT_CORE_COUNT;
  localparam int SLOTS = DEFAULT_SLOT_COUNT;
  localparam int IFCS  = DEFAULT_INTERFACE_COUNT;
  localparam int DW    = DEFAULT_DATA_WIDTH;
  localparam int KW    = DW / 8;
  localparam int SW    = $clog2(SLOTS + 1);
  localparam int CW    = $clog2(CORES);
  localparam int TW    = (SW > MIN_TAG_WIDTH) ? SW : MIN_TAG_WIDTH;
  localparam int DESTW = CW + TW;

  typedef enum {OP_INIT, OP_RETURN, OP_DONE, OP_FULL, OP_STALL, OP_MASK, OP_QUERY,
                OP_PKT, OP_BLOCK} op_e;

  logic                  clk;
  logic                  rst;
  logic [CTRL_WIDTH-1:0] ctrl_s_data;
  logic [CW-1:0]         ctrl_s_src;
  logic                  ctrl_s_valid;
  logic                  ctrl_s_ready;
  logic [CTRL_WIDTH-1:0] ctrl_m_data;
  logic [CW-1:0]         ctrl_m_dest;
  logic                  ctrl_m_valid;
  logic                  ctrl_m_ready;
  logic [IFCS*DW-1:0]    rx_data;
  logic [IFCS*KW-1:0]    rx_keep;
  logic [IFCS-1:0]       rx_valid;
  logic [IFCS-1:0]       rx_last;
  logic [IFCS-1:0]       rx_ready;
  logic [IFCS*DW-1:0]    data_m_data;
  logic [IFCS*KW-1:0]    data_m_keep;
  logic [IFCS-1:0]       data_m_valid;
  logic [IFCS-1:0]       data_m_last;
  logic [IFCS*DESTW-1:0] data_m_dest;
  logic [IFCS-1:0]       data_m_ready;
  logic [CORES-1:0]      income_cores;
  logic [CW-1:0]         slot_query_core;
  logic [SW-1:0]         slot_query_count;

  op_e                   tbl_op[$];
  int                    tbl_ifc[$];
  int                    tbl_core[$];
  logic [31:0]           tbl_val[$];
  logic [31:0]           tbl_exp[$];
  logic [CTRL_WIDTH-1:0] exp_msg[$];
  logic [CW-1:0]         exp_dest[$];

  // Reference slot queues, one per core, plus the destination each interface holds
  int               m_slot[CORES][SLOTS];
  int               m_head[CORES];
  int               m_count[CORES];
  logic [CORES-1:0] m_mask;
  logic [IFCS-1:0]  m_held;
  int               m_dest[IFCS];
  int               m_last;

  logic [31:0] rng = 32'h4f96_9796;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(3)) u_clock (.clk(clk), .rst(rst));

  scheduler_top #(
    .CORE_COUNT(CORES), .SLOT_COUNT(SLOTS), .INTERFACE_COUNT(IFCS), .DATA_WIDTH(DW)
  ) u_dut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic void add_row(op_e op, int ifc, int core, logic [31:0] val,
                                  logic [31:0] exp);
    tbl_op.push_back(op);
    tbl_ifc.push_back(ifc);
    tbl_core.push_back(core);
    tbl_val.push_back(val);
    tbl_exp.push_back(exp);
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    value_errors++;
    $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  function automatic void model_init(int c, int n);
    m_head[c]  = 0;
    m_count[c] = (n > SLOTS) ? SLOTS : n;
    for (int k = 0; k < SLOTS; k++) m_slot[c][k] = k + 1;
  endfunction

  function automatic void model_return(int c, int s);
    if (m_count[c] < SLOTS) begin
      m_slot[c][(m_head[c] + m_count[c]) % SLOTS] = s;
      m_count[c]++;
    end
  endfunction

  // Idle interfaces take the fullest enabled core, round robin after the last grant
  function automatic void model_grab();
    int start;
    int cand;
    int best;
    start = m_last;
    for (int k = 1; k <= IFCS; k++) begin
      cand = (start + k) % IFCS;
      best = -1;
      for (int c = 0; c < CORES; c++) begin
        if (m_mask[c] && m_count[c] > 0 && (best < 0 || m_count[c] > m_count[best])) best = c;
      end
      if (!m_held[cand] && best >= 0) begin
        m_held[cand] = 1'b1;
        m_dest[cand] = (best << TW) | m_slot[best][m_head[best]];
        m_head[best] = (m_head[best] + 1) % SLOTS;
        m_count[best]--;
        m_last = cand;
      end
    end
  endfunction

  task automatic send_ctrl(input msg_kind_e kind, input int src, input logic [31:0] desc,
                           input int idle);
    bit was_empty;
    @(negedge clk);
    ctrl_s_data  = {kind, desc};
    ctrl_s_src   = CW'(src);
    ctrl_s_valid = 1'b1;
    @(posedge clk);
    while (!ctrl_s_ready) @(posedge clk);
    was_empty = (exp_msg.size() == 0);
    if (kind == MSG_PKT_DONE) begin
      exp_msg.push_back({4'h0, desc});
      exp_dest.push_back(CW'(src));
    end
    @(negedge clk);
    ctrl_s_valid = 1'b0;
    @(posedge clk);
    if (kind == MSG_PKT_DONE && was_empty && !ctrl_m_valid)
      report_failure("packet done message missing on ctrl_m one cycle after acceptance");
    repeat (idle) @(posedge clk);
  endtask

  task automatic drive_word(input int ifc, input bit last);
    logic [DW-1:0] word;
    rng = xorshift32(rng);
    word[63:32] = rng;
    rng = xorshift32(rng);
    word[31:0] = rng;
    @(negedge clk);
    rx_data[ifc*DW +: DW] = word;
    rx_keep[ifc*KW +: KW] = word[KW-1:0];
    rx_last[ifc]          = last;
    rx_valid[ifc]         = 1'b1;
  endtask

  task automatic check_word(input int ifc);
    @(posedge clk);
    while (!rx_ready[ifc]) @(posedge clk);
    if (!m_held[ifc])
      report_failure($sformatf("interface %0d took a word while no slot was free", ifc));
    if (!data_m_valid[ifc])
      report_failure($sformatf("data_m_valid low on interface %0d during a transfer", ifc));
    if (data_m_data[ifc*DW +: DW] != rx_data[ifc*DW +: DW])
      report_mismatch("data_m_data", data_m_data[ifc*DW +: DW], rx_data[ifc*DW +: DW]);
    if (data_m_keep[ifc*KW +: KW] != rx_keep[ifc*KW +: KW])
      report_mismatch("data_m_keep", data_m_keep[ifc*KW +: KW], rx_keep[ifc*KW +: KW]);
    if (data_m_last[ifc] != rx_last[ifc])
      report_mismatch("data_m_last", data_m_last[ifc], rx_last[ifc]);
    if (data_m_dest[ifc*DESTW +: DESTW] != DESTW'(m_dest[ifc]))
      report_mismatch("data_m_dest", data_m_dest[ifc*DESTW +: DESTW], DESTW'(m_dest[ifc]));
  endtask

  task automatic finish_packet(input int ifc);
    @(negedge clk);
    rx_valid[ifc] = 1'b0;
    rx_last[ifc]  = 1'b0;
    m_held[ifc]   = 1'b0;
    model_grab();
  endtask

  // Outgoing messages in order, held stable while stalled
  always @(posedge clk) begin
    if (!rst && ctrl_m_valid) begin
      if (exp_msg.size() == 0) begin
        report_failure("ctrl_m carried a message nobody sent");
      end else begin
        if (ctrl_m_data != exp_msg[0]) report_mismatch("ctrl_m_data", ctrl_m_data, exp_msg[0]);
        if (ctrl_m_dest != exp_dest[0]) report_mismatch("ctrl_m_dest", ctrl_m_dest, exp_dest[0]);
        if (ctrl_m_ready) begin
          void'(exp_msg.pop_front());
          void'(exp_dest.pop_front());
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Run stopped after %0d cycles without finishing the table", cycle_limit);
      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    ctrl_s_data     = '0;
    ctrl_s_src      = '0;
    ctrl_s_valid    = 1'b0;
    ctrl_m_ready    = 1'b1;
    rx_data         = '0;
    rx_keep         = '0;
    rx_valid        = '0;
    rx_last         = '0;
    data_m_ready    = '1;
    income_cores    = '0;
    slot_query_core = '0;
    m_mask          = '0;
    m_held          = '0;
    m_last          = 0;
    for (int c = 0; c < CORES; c++) model_init(c, 0);

    for (int c = 0; c < CORES; c++) add_row(OP_QUERY, 0, c, 0, 0);
    add_row(OP_INIT, 0, 3, 4, 0);
    add_row(OP_INIT, 0, 7, 8, 0);
    add_row(OP_INIT, 0, 1, 2, 0);
    add_row(OP_RETURN, 0, 3, 6, 0);
    add_row(OP_RETURN, 0, 1, 5, 0);
    add_row(OP_QUERY, 0, 3, 0, 5);
    add_row(OP_QUERY, 0, 7, 0, 8);
    add_row(OP_QUERY, 0, 1, 0, 3);
    add_row(OP_DONE, 0, 2, 32'h1234_0001, 0);
    add_row(OP_DONE, 0, 9, 32'hbeef_0002, 0);
    add_row(OP_STALL, 0, 0, 0, 0);
    for (int k = 0; k < 8; k++) add_row(OP_DONE, 0, k + 4, 32'hd0e0_0000 + k * 32'h111, 0);
    add_row(OP_FULL, 0, 15, 32'hfeed_0009, 0);
    add_row(OP_STALL, 0, 0, 1, 0);
    add_row(OP_MASK, 0, 0, 32'hffff, 0);
    add_row(OP_PKT, 0, 0, 3, 0);
    add_row(OP_PKT, 1, 0, 2, 0);
    add_row(OP_QUERY, 0, 7, 0, 5);
    add_row(OP_QUERY, 0, 3, 0, 4);
    add_row(OP_PKT, 0, 0, 1, 0);
    add_row(OP_PKT, 1, 0, 4, 0);
    add_row(OP_MASK, 0, 0, 32'h0002, 0);
    add_row(OP_PKT, 0, 0, 2, 0);
    add_row(OP_PKT, 1, 0, 1, 0);
    add_row(OP_PKT, 0, 0, 1, 0);
    add_row(OP_PKT, 1, 0, 1, 0);
    // Blocked packets, released by a slot return and then by enabling cores
    add_row(OP_BLOCK, 1, 1, 7, 32'h0002);
    add_row(OP_MASK, 0, 0, 0, 0);
    add_row(OP_BLOCK, 1, 0, 0, 32'hffff);
    add_row(OP_QUERY, 0, 7, 0, 3);
    add_row(OP_QUERY, 0, 3, 0, 2);
    add_row(OP_QUERY, 0, 1, 0, 0);
    cycle_limit = tbl_op.size() * 40;

    while (rst) @(posedge clk);
    @(posedge clk);
    if (ctrl_m_valid) report_mismatch("ctrl_m_valid", ctrl_m_valid, 0);
    if (data_m_valid != '0) report_mismatch("data_m_valid", data_m_valid, 0);

    for (int r = 0; r < tbl_op.size(); r++) begin
      case (tbl_op[r])
        OP_INIT, OP_RETURN: begin
          send_ctrl((tbl_op[r] == OP_INIT) ? MSG_SLOT_INIT : MSG_SLOT_RETURN, tbl_core[r],
                    tbl_val[r] << SLOT_FIELD_LSB, 4);
          if (tbl_op[r] == OP_INIT) model_init(tbl_core[r], tbl_val[r]);
          else model_return(tbl_core[r], tbl_val[r]);
          model_grab();
        end
        OP_DONE: send_ctrl(MSG_PKT_DONE, tbl_core[r], tbl_val[r], 1);
        OP_FULL: begin
          @(negedge clk);
          ctrl_s_data  = {MSG_PKT_DONE, tbl_val[r]};
          ctrl_s_src   = CW'(tbl_core[r]);
          ctrl_s_valid = 1'b1;
          @(posedge clk);
          if (ctrl_s_ready != tbl_exp[r][0]) report_mismatch("ctrl_s_ready", ctrl_s_ready,
                                                             tbl_exp[r][0]);
          @(negedge clk);
          ctrl_s_valid = 1'b0;
        end
        OP_STALL: begin
          @(negedge clk);
          ctrl_m_ready = tbl_val[r][0];
        end
        OP_MASK: begin
          @(negedge clk);
          income_cores = tbl_val[r][CORES-1:0];
          m_mask       = tbl_val[r][CORES-1:0];
          model_grab();
          repeat (3) @(posedge clk);
        end
        OP_QUERY: begin
          @(negedge clk);
          slot_query_core = CW'(tbl_core[r]);
          @(posedge clk);
          if (slot_query_count != tbl_exp[r][SW-1:0])
            report_mismatch("slot_query_count", slot_query_count, tbl_exp[r]);
        end
        OP_PKT: begin
          for (int w = 0; w < tbl_val[r]; w++) begin
            drive_word(tbl_ifc[r], w == tbl_val[r] - 1);
            check_word(tbl_ifc[r]);
          end
          finish_packet(tbl_ifc[r]);
        end
        OP_BLOCK: begin
          drive_word(tbl_ifc[r], 1'b1);
          repeat (8) begin
            @(posedge clk);
            if (rx_ready[tbl_ifc[r]] || data_m_valid[tbl_ifc[r]])
              report_failure("packet went out while no enabled core had a slot");
          end
          if (tbl_val[r] != 0) begin
            send_ctrl(MSG_SLOT_RETURN, tbl_core[r], tbl_val[r] << SLOT_FIELD_LSB, 0);
            model_return(tbl_core[r], tbl_val[r]);
            model_grab();
          end
          @(negedge clk);
          income_cores = tbl_exp[r][CORES-1:0];
          m_mask       = tbl_exp[r][CORES-1:0];
          model_grab();
          check_word(tbl_ifc[r]);
          finish_packet(tbl_ifc[r]);
        end
        default: report_failure("table row with an unknown operation");
      endcase
    end

    repeat (20) @(posedge clk);
    if (exp_msg.size() != 0)
      report_failure($sformatf("%0d packet done messages never came out", exp_msg.size()));
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: scheduler.f
design/sched_cfg_pkg.sv
design/sched_msg_pkg.sv
design/ctrl_msg_decoder.sv
design/slot_keeper.sv
design/done_msg_queue.sv
design/max_slot_selector.sv
design/rx_dest_assigner.sv
design/scheduler_top.sv
testbench/tb_clock_gen.sv
testbench/tb_scheduler_top.sv

// File: Bender.yml
package:
  name: scheduler

sources:
  - files:
      - design/sched_cfg_pkg.sv
      - design/sched_msg_pkg.sv
      - design/ctrl_msg_decoder.sv
      - design/slot_keeper.sv
      - design/done_msg_queue.sv
      - design/max_slot_selector.sv
      - design/rx_dest_assigner.sv
      - design/scheduler_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_scheduler_top.sv
